//--- hdl/dataPort.sv
`timescale 1ns/1ps

module dataPort (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    input  lsuPkg::lsReq_t               head,
    input  logic                         headValid,
    output logic                         pop,
    memAccessIf.port                     mem,
    output logic                         respDone,
    output logic [lsuPkg::DataWidth-1:0] respData,
    output logic [lsuPkg::NickWidth-1:0] respNick
);
    import lsuPkg::*;

    lsReq_t cur;
    logic   occupied;
    logic   startQ;

    // The head is taken in the same edge that launches the access.
    assign pop = rdy && !occupied && headValid;

    assign mem.en    = startQ;
    assign mem.ls    = cur.ls;
    assign mem.addr  = cur.addr;
    assign mem.wdata = cur.data;
    assign mem.len   = cur.len;

    always_ff @(posedge clk) begin
        if (pop) begin
            cur <= head;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= 1'b0;
            startQ   <= 1'b0;
            respDone <= 1'b0;
            respData <= '0;
            respNick <= '0;
        end else if (rdy) begin
            startQ   <= pop;
            respDone <= 1'b0;

            if (mem.done) begin
                respDone <= 1'b1;
                respData <= cur.ls ? '0 : mem.rdata;
                respNick <= cur.nick;
                occupied <= 1'b0;
            end

            if (pop) begin
                occupied <= 1'b1;
            end
        end else begin
            // A completion never lingers across a stalled cycle.
            respDone <= 1'b0;
        end
    end

endmodule

//--- hdl/dataRam.sv
`timescale 1ns/1ps

module dataRam (
    input  logic                         clk,
    input  logic                         we,
    input  logic [lsuPkg::AddrWidth-1:0] addr,
    input  logic [7:0]                   wdata,
    output logic [7:0]                   rdata
);
    import lsuPkg::*;

    logic [7:0] bytes [RamDepth];

    initial begin
        for (int i = 0; i < RamDepth; i++) begin
            bytes[i] = 8'h00;
        end
    end

    // Read returns the old contents when the same byte is written.
    always_ff @(posedge clk) begin
        if (we) begin
            bytes[addr] <= wdata;
        end
        rdata <= bytes[addr];
    end

endmodule

//--- hdl/lsQueue.sv
`timescale 1ns/1ps

module lsQueue (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdy,
    input  logic                          reqEn,
    input  logic                          reqLs,
    input  logic [lsuPkg::AddrWidth-1:0]  reqAddr,
    input  logic [lsuPkg::DataWidth-1:0]  reqData,
    input  lsuPkg::lenCode_t              reqLen,
    input  logic [lsuPkg::NickWidth-1:0]  reqNick,
    output logic                          full,
    output lsuPkg::lsReq_t                head,
    output logic                          headValid,
    input  logic                          pop
);
    import lsuPkg::*;

    lsReq_t                entries [QueueDepth];
    logic [PtrWidth-1:0]   wrPtr;
    logic [PtrWidth-1:0]   rdPtr;
    logic [CountWidth-1:0] count;
    logic                  push;
    logic                  doPop;

    assign full      = (count == CountWidth'(QueueDepth));
    assign headValid = (count != '0);
    assign head      = entries[rdPtr];

    // A request offered while full is simply not taken; the core retries.
    assign push  = rdy && reqEn && !full;
    assign doPop = rdy && pop && headValid;

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= '{
                ls:   reqLs,
                addr: reqAddr,
                data: reqData,
                len:  reqLen,
                nick: reqNick
            };
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (rdy) begin
            if (push) begin
                wrPtr <= wrPtr + PtrWidth'(1);
            end
            if (doPop) begin
                rdPtr <= rdPtr + PtrWidth'(1);
            end

            // A push and a pop in the same cycle leave the count as it is.
            case ({push, doPop})
                2'b10: begin
                    count <= count + CountWidth'(1);
                end
                2'b01: begin
                    count <= count - CountWidth'(1);
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

//--- hdl/lsuPkg.sv
package lsuPkg;

    localparam int AddrWidth  = 10;
    localparam int DataWidth  = 32;
    localparam int NickWidth  = 4;
    localparam int QueueDepth = 4;

    // The queue pointers wrap naturally, so QueueDepth must be a power of two.
    localparam int PtrWidth   = $clog2(QueueDepth);
    localparam int CountWidth = $clog2(QueueDepth + 1);
    localparam int RamDepth   = 1 << AddrWidth;

    // Access length in bytes. Only 1, 2 and 4 are legal.
    typedef logic [2:0] lenCode_t;

    typedef struct packed {
        logic                 ls;
        logic [AddrWidth-1:0] addr;
        logic [DataWidth-1:0] data;
        lenCode_t             len;
        logic [NickWidth-1:0] nick;
    } lsReq_t;

    // A data word seen whole by the port and byte by byte by the controller.
    typedef union packed {
        logic [DataWidth-1:0]          word;
        logic [DataWidth/8-1:0][7:0]   bytes;
    } memWord_t;

endpackage

//--- hdl/lsuTop.sv
`timescale 1ns/1ps

module lsuTop (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    input  logic                         reqEn,
    input  logic                         reqLs,
    input  logic [lsuPkg::AddrWidth-1:0] reqAddr,
    input  logic [lsuPkg::DataWidth-1:0] reqData,
    input  lsuPkg::lenCode_t             reqLen,
    input  logic [lsuPkg::NickWidth-1:0] reqNick,
    output logic                         full,
    output logic                         respDone,
    output logic [lsuPkg::DataWidth-1:0] respData,
    output logic [lsuPkg::NickWidth-1:0] respNick
);
    import lsuPkg::*;

    lsReq_t               head;
    logic                 headValid;
    logic                 pop;
    logic                 ramWe;
    logic [AddrWidth-1:0] ramAddr;
    logic [7:0]           ramWdata;
    logic [7:0]           ramRdata;

    memAccessIf memBus ();

    lsQueue lsQueue_i (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .reqEn     (reqEn),
        .reqLs     (reqLs),
        .reqAddr   (reqAddr),
        .reqData   (reqData),
        .reqLen    (reqLen),
        .reqNick   (reqNick),
        .full      (full),
        .head      (head),
        .headValid (headValid),
        .pop       (pop)
    );

    dataPort dataPort_i (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .head      (head),
        .headValid (headValid),
        .pop       (pop),
        .mem       (memBus.port),
        .respDone  (respDone),
        .respData  (respData),
        .respNick  (respNick)
    );

    memCtrl memCtrl_i (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .mem      (memBus.ctrl),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

    dataRam dataRam_i (
        .clk   (clk),
        .we    (ramWe),
        .addr  (ramAddr),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

endmodule

//--- hdl/memAccessIf.sv
`timescale 1ns/1ps

interface memAccessIf;
    import lsuPkg::*;

    logic                 en;
    logic                 ls;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    lenCode_t             len;
    logic                 done;
    logic [DataWidth-1:0] rdata;

    // The data port starts an access and holds its fields until done.
    modport port (
        output en,
        output ls,
        output addr,
        output wdata,
        output len,
        input  done,
        input  rdata
    );

    modport ctrl (
        input  en,
        input  ls,
        input  addr,
        input  wdata,
        input  len,
        output done,
        output rdata
    );

endinterface

//--- hdl/memCtrl.sv
`timescale 1ns/1ps

module memCtrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    memAccessIf.ctrl                     mem,
    output logic                         ramWe,
    output logic [lsuPkg::AddrWidth-1:0] ramAddr,
    output logic [7:0]                   ramWdata,
    input  logic [7:0]                   ramRdata
);
    import lsuPkg::*;

    logic     busy;
    logic     doneQ;
    logic     active;
    logic [2:0] step;
    logic [2:0] curStep;
    logic [2:0] readStep;
    logic [1:0] byteIdx;
    memWord_t wWord;
    memWord_t rWord;

    // Step 0 runs in the cycle of en, so the access fields are read straight
    // from the interface, which holds them until done.
    assign active  = mem.en || busy;
    assign curStep = busy ? step : 3'd0;
    assign byteIdx = curStep[1:0] - 2'd1;

    // While stalled, the previous byte is addressed again so that the RAM
    // output still holds it when the stall ends.
    assign readStep = rdy ? curStep : curStep - 3'd1;

    assign wWord.word = mem.wdata;
    assign ramAddr    = mem.addr + AddrWidth'(readStep);
    assign ramWdata   = wWord.bytes[curStep[1:0]];
    assign ramWe      = rdy && active && mem.ls && (curStep < mem.len);

    assign mem.done  = doneQ;
    assign mem.rdata = rWord.word;

    always_ff @(posedge clk) begin
        if (rdy && active) begin
            if (curStep == 3'd0) begin
                rWord.word <= '0;
            end else if (!mem.ls) begin
                rWord.bytes[byteIdx] <= ramRdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            step  <= 3'd0;
            doneQ <= 1'b0;
        end else if (rdy) begin
            doneQ <= 1'b0;
            if (active) begin
                // The step after the last byte collects the final RAM read.
                if (curStep == mem.len) begin
                    busy  <= 1'b0;
                    step  <= 3'd0;
                    doneQ <= 1'b1;
                end else begin
                    busy <= 1'b1;
                    step <= curStep + 3'd1;
                end
            end
        end
    end

endmodule

//--- sim/lsuTb.sv
`timescale 1ns/1ps

module lsuTb;
    import lsuPkg::*;

    localparam int AcceptLimit = 1000;
    localparam int DrainLimit  = 4000;
    localparam int StallCycles = 20;

    logic                 clk;
    logic                 rst;
    logic                 rdy;
    logic                 reqEn;
    logic                 reqLs;
    logic [AddrWidth-1:0] reqAddr;
    logic [DataWidth-1:0] reqData;
    lenCode_t             reqLen;
    logic [NickWidth-1:0] reqNick;
    logic                 full;
    logic                 respDone;
    logic [DataWidth-1:0] respData;
    logic [NickWidth-1:0] respNick;

    logic [31:0]          lfsr;
    logic                 rdyRandom;
    logic                 rdyLevel;
    logic                 sawFull;
    int                   accepted;
    int                   completed;
    logic [DataWidth-1:0] expData [$];
    logic [NickWidth-1:0] expNick [$];
    string                expName [$];

    lsuTop lsuTop_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic logic [31:0] lfsrStep(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1);
    endfunction

    task automatic stopRun(string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            stopRun($sformatf("ERR %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // Two LFSR bits per cycle keep rdy high three cycles in four.
    always @(posedge clk) begin : rdyDrive
        logic bitA;
        logic bitB;
        if (rdyRandom) begin
            lfsr = lfsrStep(lfsr);
            bitA = lfsr[0];
            lfsr = lfsrStep(lfsr);
            bitB = lfsr[0];
            rdy <= bitA | bitB;
        end else begin
            rdy <= rdyLevel;
        end
    end

    // Completions must come back in request order.
    always @(negedge clk) begin
        if (!rst && full) begin
            sawFull = 1'b1;
        end
        if (!rst && respDone) begin
            if (expData.size() == 0) begin
                stopRun("a completion arrived with no request outstanding");
            end else begin
                checkValue({expName[0], " data"}, expData[0], respData);
                checkValue({expName[0], " nick"}, 32'(expNick[0]), 32'(respNick));
                expData.delete(0);
                expNick.delete(0);
                expName.delete(0);
                completed++;
            end
        end
    end

    task automatic sendReq(string name, logic ls, logic [AddrWidth-1:0] addr, lenCode_t len,
                           logic [DataWidth-1:0] data, logic [NickWidth-1:0] nick,
                           logic [DataWidth-1:0] expWord);
        int waited = 0;
        reqEn   <= 1'b1;
        reqLs   <= ls;
        reqAddr <= addr;
        reqLen  <= len;
        reqData <= data;
        reqNick <= nick;
        @(negedge clk);
        while (!(rdy && !full)) begin
            @(negedge clk);
            waited++;
            if (waited > AcceptLimit) begin
                stopRun($sformatf("request %s was never accepted", name));
            end
        end
        @(posedge clk);
        accepted++;
        expData.push_back(expWord);
        expNick.push_back(nick);
        expName.push_back(name);
    endtask

    task automatic drain();
        int waited = 0;
        while (completed != accepted) begin
            @(posedge clk);
            waited++;
            if (waited > DrainLimit) begin
                stopRun("timed out waiting for outstanding completions");
            end
        end
    endtask

    task automatic holdStall();
        logic fullRef;
        @(negedge clk);
        rdyLevel = 1'b0;
        @(negedge clk);
        fullRef = full;
        for (int i = 0; i < StallCycles; i++) begin
            @(negedge clk);
            checkValue("stall respDone", 32'(1'b0), 32'(respDone));
            checkValue("stall full", 32'(fullRef), 32'(full));
        end
        rdyLevel = 1'b1;
        @(posedge clk);
    endtask

    task automatic endGroup(int mode);
        reqEn <= 1'b0;
        if (mode == 1) begin
            checkValue("burst full seen", 32'(1'b1), 32'(sawFull));
            holdStall();
        end
        drain();
    endtask

    initial begin
        int                   fd;
        int                   got;
        int                   mode;
        int                   curMode;
        string                line;
        string                name;
        logic                 ls;
        logic [AddrWidth-1:0] addr;
        lenCode_t             len;
        logic [DataWidth-1:0] data;
        logic [NickWidth-1:0] nick;
        logic [DataWidth-1:0] expWord;
        rst       = 1'b1;
        rdy       = 1'b1;
        reqEn     = 1'b0;
        reqLs     = 1'b0;
        reqAddr   = '0;
        reqData   = '0;
        reqLen    = 3'd1;
        reqNick   = '0;
        lfsr      = 32'h1b49caf7;
        rdyRandom = 1'b0;
        rdyLevel  = 1'b1;
        sawFull   = 1'b0;
        accepted  = 0;
        completed = 0;
        curMode   = -1;
        fd = $fopen("sim/lsu_testdata.txt", "r");
        if (fd == 0) begin
            stopRun("cannot open sim/lsu_testdata.txt");
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("reset full", 32'(1'b0), 32'(full));
        checkValue("reset respDone", 32'(1'b0), 32'(respDone));
        @(posedge clk);
        while (!$feof(fd)) begin
            line = "";
            got = $fgets(line, fd);
            if (got > 0 && line.len() > 0 && line.getc(0) != "#") begin
                got = $sscanf(line, "%s %d %d %h %d %h %h %h",
                              name, mode, ls, addr, len, data, nick, expWord);
                if (got == 8) begin
                    // Serial lines drain before each request; a mode change drains the group.
                    if (mode != curMode || mode == 0) begin
                        endGroup(curMode);
                        @(negedge clk);
                        rdyRandom = (mode == 2);
                        sawFull   = 1'b0;
                        curMode   = mode;
                        @(posedge clk);
                    end
                    sendReq(name, ls, addr, len, data, nick, expWord);
                end
            end
        end
        endGroup(curMode);
        $fclose(fd);
        if (accepted > 0 && accepted == completed && expData.size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            stopRun("request and completion counts do not match");
        end
    end

endmodule

//--- sim/lsuTop_properties.sv
`timescale 1ns/1ps

module lsuTop_properties (
    input logic clk,
    input logic rst,
    input logic rdy,
    input logic full,
    input logic respDone
);

    // A completion is a single-cycle pulse.
    singlePulse: assert property (@(posedge clk) disable iff (rst) respDone |=> !respDone)
        else $error("respDone stayed high for two cycles");

    resetQuiet: assert property (@(posedge clk) $fell(rst) |-> (!respDone && !full))
        else $error("respDone or full high in the first cycle after reset");

    // No completion may follow a stalled cycle.
    noStallResp: assert property (@(posedge clk) disable iff (rst) respDone |-> $past(rdy))
        else $error("respDone raised after a cycle with rdy low");

endmodule

bind lsuTop lsuTop_properties lsuTopProps_i (
    .clk      (clk),
    .rst      (rst),
    .rdy      (rdy),
    .full     (full),
    .respDone (respDone)
);

//--- sim/lsu_testdata.txt
# name mode(0 serial, 1 burst, 2 burst with random rdy) ls(1 store) addr len data nick expected
# Mode, ls and len are decimal, the other values after the name are hex.
ldUntouched 0 0 040 4 00000000 1 00000000
stWord      0 1 010 4 a1b2c3d4 2 00000000
ldWord      0 0 010 4 00000000 3 a1b2c3d4
stByte      0 1 011 1 123456ee 4 00000000
stHalf      0 1 012 2 9abc5566 5 00000000
ldMerged    0 0 010 4 00000000 6 5566eed4
ldByte      0 0 011 1 00000000 7 000000ee
ldHalf      0 0 012 2 00000000 8 00005566
burstStore  1 1 020 4 11223344 9 00000000
burstWord   1 0 020 4 00000000 a 11223344
burstHalfHi 1 0 022 2 00000000 b 00001122
burstByte1  1 0 021 1 00000000 c 00000033
burstHalfLo 1 0 020 2 00000000 d 00003344
burstByte3  1 0 023 1 00000000 e 00000011
rndStWord   2 1 3fc 4 cafef00d f 00000000
rndStHalf   2 1 3fe 2 1234beef 0 00000000
rndLdWord   2 0 3fc 4 00000000 1 beeff00d
rndLdByte   2 0 3fd 1 00000000 2 000000f0
rndLdHalf   2 0 3fe 2 00000000 3 0000beef

//--- sources.f
hdl/lsuPkg.sv
hdl/memAccessIf.sv
hdl/lsQueue.sv
hdl/dataPort.sv
hdl/memCtrl.sv
hdl/dataRam.sv
hdl/lsuTop.sv
sim/lsuTop_properties.sv
sim/lsuTb.sv
